//--- run_sim.sh
#!/bin/sh
# build the core testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module core_tb -f vlog.f -o core_tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/core_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

exit 0

//--- verification/core_tb.sv
`timescale 1ns/1ps

module core_tb;

	// reset window, program and pipeline drain per test
	localparam int TEST_LEN_SUM = 12 + 28 + 24 + 29 + 23;

	logic            clk;
	logic            rst = 1'b1;
	core_pkg::word_t instr_addr;
	core_pkg::word_t instr;
	core_pkg::word_t data_addr;
	core_pkg::word_t write_data;
	core_pkg::word_t read_data;
	logic            mem_write;
	logic            mem_read;
	core_pkg::word_t prog [64];
	core_pkg::word_t log_addr [16];
	core_pkg::word_t log_data [16];
	int              store_count;
	int              prog_len = 0;
	int              seed = 32'h1c3b_42f7;
	int              errors = 0;
	int              errors_at_start = 0;
	int              passed = 0;
	int              failed = 0;
	string           test_name = "none";

	tb_clock clock_inst (
		.o_clk(clk)
	);

	tb_memory memory_inst (
		.i_clk        (clk),
		.i_reset      (rst),
		.i_program    (prog),
		.i_instr_addr (instr_addr),
		.o_instr      (instr),
		.i_data_addr  (data_addr),
		.i_write_data (write_data),
		.i_mem_write  (mem_write),
		.o_read_data  (read_data),
		.o_store_count(store_count),
		.o_log_addr   (log_addr),
		.o_log_data   (log_data)
	);

	core core_inst (
		.i_clk                (clk),
		.i_reset              (rst),
		.i_read_instruction   (instr),
		.i_read_data          (read_data),
		.o_instruction_address(instr_addr),
		.o_data_address       (data_addr),
		.o_write_data         (write_data),
		.o_mem_write          (mem_write),
		.o_mem_read           (mem_read)
	);

	function automatic core_pkg::word_t sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic core_pkg::word_t rtype_word(input core_pkg::funct_e f,
		input core_pkg::reg_addr_t rd, input core_pkg::reg_addr_t rs,
		input core_pkg::reg_addr_t rt);
		return {6'h00, rs, rt, rd, 5'd0, f};
	endfunction

	// rt is the destination or the stored or compared register
	function automatic core_pkg::word_t itype_word(input core_pkg::opcode_e op,
		input core_pkg::reg_addr_t rt, input core_pkg::reg_addr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic core_pkg::word_t jump_word(input logic [25:0] index);
		return {core_pkg::J, index};
	endfunction

	task automatic emit(input core_pkg::word_t w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	// self-jump parks the core after its last store
	task automatic emit_halt();
		emit(jump_word(26'(prog_len)));
	endtask

	task automatic check_word(input string what, input core_pkg::word_t exp,
		input core_pkg::word_t act);
		if (act !== exp) begin
			$display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_addr(input string what, input core_pkg::word_t exp,
		input core_pkg::word_t act);
		if (act !== exp) begin
			$display("MISMATCH %s %s: expected address %h, actual %h",
				test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_store(input int idx, input core_pkg::word_t exp_addr,
		input core_pkg::word_t exp_data);
		string what;
		what = $sformatf("store %0d", idx);
		check_addr({what, " address"}, exp_addr, log_addr[idx]);
		check_word({what, " data"}, exp_data, log_data[idx]);
	endtask

	// core held in reset while the new program is loaded
	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = errors;
		@(posedge clk);
		rst <= 1'b1;
		@(posedge clk);
		prog_len = 0;
		for (int i = 0; i < 64; i++) begin
			prog[i] = '0;
		end
	endtask

	task automatic run_program(input int n_stores);
		repeat (9) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		while (store_count < n_stores) begin
			@(negedge clk);
		end
	endtask

	task automatic end_test();
		if (errors == errors_at_start) begin
			$display("PASS %s", test_name);
			passed++;
		end else begin
			$display("FAIL %s with %0d errors", test_name, errors - errors_at_start);
			failed++;
		end
	endtask

	task automatic reset_state();
		begin_test("reset");
		emit_halt();
		run_program(0);
		check_addr("pc", core_pkg::RESET_PC, instr_addr);
		check_flag("mem_write", 1'b0, mem_write);
		check_flag("mem_read", 1'b0, mem_read);
		end_test();
	endtask

	// every instruction consumes the result just before it
	task automatic arith_chain();
		core_pkg::word_t rnd;
		core_pkg::word_t r [8];
		logic [15:0]     imm_a;
		logic [15:0]     imm_b;
		rnd = $random(seed);
		imm_a = rnd[15:0];
		rnd = $random(seed);
		imm_b = rnd[15:0];
		r[1] = sext16(imm_a);
		r[2] = r[1] + sext16(imm_b);
		r[3] = r[2] + r[1];
		r[4] = r[1] - r[3];
		r[5] = r[4] & r[3];
		r[6] = r[5] | r[2];
		r[7] = ($signed(r[6]) < $signed(r[4])) ? 32'd1 : 32'd0;
		begin_test("arith");
		emit(itype_word(core_pkg::ADDIU, 5'd1, 5'd0, imm_a));
		emit(itype_word(core_pkg::ADDIU, 5'd2, 5'd1, imm_b));
		emit(rtype_word(core_pkg::ADDU, 5'd3, 5'd2, 5'd1));
		emit(rtype_word(core_pkg::SUBU, 5'd4, 5'd1, 5'd3));
		emit(rtype_word(core_pkg::AND, 5'd5, 5'd4, 5'd3));
		emit(rtype_word(core_pkg::OR, 5'd6, 5'd5, 5'd2));
		emit(rtype_word(core_pkg::SLT, 5'd7, 5'd6, 5'd4));
		for (int i = 3; i <= 7; i++) begin
			emit(itype_word(core_pkg::SW, 5'(i), 5'd0, 16'(4 * (i - 3))));
		end
		emit_halt();
		run_program(5);
		for (int i = 3; i <= 7; i++) begin
			check_store(i - 3, 32'(4 * (i - 3)), r[i]);
		end
		end_test();
	endtask

	task automatic load_use();
		core_pkg::word_t rnd;
		logic [15:0]     imm_a;
		logic [15:0]     imm_b;
		rnd = $random(seed);
		imm_a = rnd[15:0];
		rnd = $random(seed);
		imm_b = rnd[15:0];
		begin_test("load_use");
		emit(itype_word(core_pkg::ADDIU, 5'd1, 5'd0, 16'h0040));
		emit(itype_word(core_pkg::ADDIU, 5'd2, 5'd0, imm_a));
		emit(itype_word(core_pkg::ADDIU, 5'd3, 5'd0, imm_b));
		emit(itype_word(core_pkg::SW, 5'd2, 5'd1, 16'h0008));
		emit(itype_word(core_pkg::LW, 5'd4, 5'd1, 16'h0008));
		// needs the load result right away
		emit(rtype_word(core_pkg::ADDU, 5'd5, 5'd4, 5'd3));
		emit(itype_word(core_pkg::SW, 5'd5, 5'd1, 16'h000c));
		emit_halt();
		run_program(2);
		check_store(0, 32'h0000_0048, sext16(imm_a));
		check_store(1, 32'h0000_004c, sext16(imm_a) + sext16(imm_b));
		end_test();
	endtask

	task automatic branches();
		begin_test("branches");
		emit(itype_word(core_pkg::ADDIU, 5'd1, 5'd0, 16'd5));
		emit(itype_word(core_pkg::ADDIU, 5'd2, 5'd0, 16'd5));
		emit(itype_word(core_pkg::ADDIU, 5'd3, 5'd0, 16'h0077));
		// taken branch lands two words past the markers
		emit(itype_word(core_pkg::BEQ, 5'd2, 5'd1, 16'd2));
		emit(itype_word(core_pkg::SW, 5'd3, 5'd0, 16'h0020));
		emit(itype_word(core_pkg::SW, 5'd3, 5'd0, 16'h0024));
		emit(itype_word(core_pkg::SW, 5'd1, 5'd0, 16'h0028));
		emit(itype_word(core_pkg::ADDIU, 5'd4, 5'd0, 16'd6));
		// not taken since 5 != 6
		emit(itype_word(core_pkg::BEQ, 5'd4, 5'd1, 16'd1));
		emit(itype_word(core_pkg::SW, 5'd4, 5'd0, 16'h002c));
		emit(itype_word(core_pkg::SW, 5'd2, 5'd0, 16'h0030));
		emit_halt();
		run_program(3);
		check_store(0, 32'h0000_0028, 32'd5);
		check_store(1, 32'h0000_002c, 32'd6);
		check_store(2, 32'h0000_0030, 32'd5);
		end_test();
	endtask

	task automatic jump_and_r0();
		begin_test("jump");
		emit(itype_word(core_pkg::ADDIU, 5'd1, 5'd0, 16'h1234));
		emit(jump_word(26'd3));
		emit(itype_word(core_pkg::SW, 5'd1, 5'd0, 16'h0050));
		emit(itype_word(core_pkg::SW, 5'd1, 5'd0, 16'h0054));
		// r0 stays zero even right after a write to it
		emit(itype_word(core_pkg::ADDIU, 5'd0, 5'd0, 16'h0055));
		emit(itype_word(core_pkg::SW, 5'd0, 5'd0, 16'h0058));
		emit_halt();
		run_program(2);
		check_store(0, 32'h0000_0054, 32'h0000_1234);
		check_store(1, 32'h0000_0058, 32'h0000_0000);
		end_test();
	endtask

	initial begin
		for (int i = 0; i < 64; i++) begin
			prog[i] = '0;
		end
		reset_state();
		arith_chain();
		load_use();
		branches();
		jump_and_r0();
		$display("tests passed %0d, failed %0d, check errors %0d", passed, failed, errors);
		if (failed == 0 && errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// four cycles per cycle of expected test length
	initial begin
		repeat (4 * TEST_LEN_SUM) @(posedge clk);
		$display("timeout in %s: the expected stores did not arrive", test_name);
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic o_clk
);

	// 8 ns period starting low
	always begin
		o_clk = 1'b0;
		#4;
		o_clk = 1'b1;
		#4;
	end

endmodule

//--- verification/tb_memory.sv
`timescale 1ns/1ps

module tb_memory (
	input  logic            i_clk,
	input  logic            i_reset,
	input  core_pkg::word_t i_program [64],
	input  core_pkg::word_t i_instr_addr,
	output core_pkg::word_t o_instr,
	input  core_pkg::word_t i_data_addr,
	input  core_pkg::word_t i_write_data,
	input  logic            i_mem_write,
	output core_pkg::word_t o_read_data,
	output int              o_store_count,
	output core_pkg::word_t o_log_addr [16],
	output core_pkg::word_t o_log_data [16]
);

	core_pkg::word_t dmem [64];

	// both memories read combinationally, word addressed
	assign o_instr = i_program[i_instr_addr[7:2]];
	assign o_read_data = dmem[i_data_addr[7:2]];

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			for (int i = 0; i < 64; i++) begin
				// fill word carries its own byte address
				dmem[i] <= 32'hd00d_0000 | 32'(i << 2);
			end
			o_store_count <= 0;
		end else if (i_mem_write) begin
			dmem[i_data_addr[7:2]] <= i_write_data;
			if (o_store_count < 16) begin
				o_log_addr[o_store_count] <= i_data_addr;
				o_log_data[o_store_count] <= i_write_data;
				o_store_count <= o_store_count + 1;
			end
		end
	end

endmodule

//--- verilog/core.sv
`timescale 1ns/1ps

module core (
	input  logic            i_clk,
	input  logic            i_reset,
	input  core_pkg::word_t i_read_instruction,
	input  core_pkg::word_t i_read_data,
	output core_pkg::word_t o_instruction_address,
	output core_pkg::word_t o_data_address,
	output core_pkg::word_t o_write_data,
	output logic            o_mem_write,
	output logic            o_mem_read
);

	core_pkg::if_id_t  if_id;
	core_pkg::id_ex_t  id_ex;
	core_pkg::ex_mem_t ex_mem;
	core_pkg::wb_t     wb;
	core_pkg::word_t   jump_target;
	core_pkg::word_t   branch_target;
	logic              stall;
	logic              jump;
	logic              branch_taken;

	fetch u_fetch (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_stall        (stall),
		.i_jump         (jump),
		.i_jump_target  (jump_target),
		.i_branch_taken (branch_taken),
		.i_branch_target(branch_target),
		.i_instr        (i_read_instruction),
		.o_pc           (o_instruction_address),
		.o_if_id        (if_id)
	);

	decode u_decode (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_if_id       (if_id),
		.i_id_ex       (id_ex),
		.i_branch_taken(branch_taken),
		.i_wb          (wb),
		.o_stall       (stall),
		.o_jump        (jump),
		.o_jump_target (jump_target),
		.o_id_ex       (id_ex)
	);

	execute u_execute (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_id_ex        (id_ex),
		.i_wb           (wb),
		.o_ex_mem       (ex_mem),
		.o_branch_taken (branch_taken),
		.o_branch_target(branch_target)
	);

	mem u_mem (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_ex_mem   (ex_mem),
		.i_read_data(i_read_data),
		.o_wb       (wb)
	);

	// data port straight from ex/mem
	assign o_data_address = ex_mem.alu_res;
	assign o_write_data = ex_mem.store_data;
	assign o_mem_write = ex_mem.mem_write;
	assign o_mem_read = ex_mem.mem_read;

endmodule

//--- verilog/core_pkg.sv
package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	localparam word_t RESET_PC = 32'h0000_0000;

	// primary opcode field in instr[31:26]
	typedef enum logic [5:0] {
		R_TYPE = 6'h00,
		J      = 6'h02,
		BEQ    = 6'h04,
		ADDIU  = 6'h09,
		LW     = 6'h23,
		SW     = 6'h2b
	} opcode_e;

	// funct field of r-type in instr[5:0]
	typedef enum logic [5:0] {
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		SLT  = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_e;

	typedef struct packed {
		word_t pc4;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		word_t     pc4;
		word_t     rs_data;
		word_t     rt_data;
		word_t     imm;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dest;
		alu_op_e   alu_op;
		logic      alu_src_imm;
		logic      mem_read;
		logic      mem_write;
		logic      reg_write;
		logic      mem_to_reg;
		logic      branch;
		logic      valid;
	} id_ex_t;

	typedef struct packed {
		word_t     alu_res;
		word_t     store_data;
		reg_addr_t dest;
		logic      mem_read;
		logic      mem_write;
		logic      reg_write;
		logic      mem_to_reg;
	} ex_mem_t;

	// writeback result and late forwarding source
	typedef struct packed {
		logic      reg_write;
		reg_addr_t dest;
		word_t     data;
	} wb_t;

endpackage

//--- verilog/decode.sv
`timescale 1ns/1ps

module decode (
	input  logic              i_clk,
	input  logic              i_reset,
	input  core_pkg::if_id_t  i_if_id,
	input  core_pkg::id_ex_t  i_id_ex,
	input  logic              i_branch_taken,
	input  core_pkg::wb_t     i_wb,
	output logic              o_stall,
	output logic              o_jump,
	output core_pkg::word_t   o_jump_target,
	output core_pkg::id_ex_t  o_id_ex
);

	core_pkg::word_t     regs [32];
	core_pkg::word_t     instr;
	core_pkg::opcode_e   opcode;
	core_pkg::funct_e    funct;
	core_pkg::reg_addr_t rs;
	core_pkg::reg_addr_t rt;
	core_pkg::id_ex_t    id_ex_next;
	logic                use_rs;
	logic                use_rt;

	// read port with write-through from writeback
	function automatic core_pkg::word_t read_reg(input core_pkg::reg_addr_t a);
		if (i_wb.reg_write && i_wb.dest == a && a != 5'd0) begin
			return i_wb.data;
		end
		return regs[a];
	endfunction

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wb.reg_write && i_wb.dest != 5'd0) begin
			regs[i_wb.dest] <= i_wb.data;
		end
	end

	assign instr = i_if_id.instr;
	assign opcode = core_pkg::opcode_e'(instr[31:26]);
	assign funct = core_pkg::funct_e'(instr[5:0]);
	assign rs = instr[25:21];
	assign rt = instr[20:16];

	always_comb begin
		id_ex_next = '0;
		id_ex_next.pc4 = i_if_id.pc4;
		id_ex_next.rs_data = read_reg(rs);
		id_ex_next.rt_data = read_reg(rt);
		id_ex_next.imm = {{16{instr[15]}}, instr[15:0]};
		id_ex_next.rs = rs;
		id_ex_next.rt = rt;
		id_ex_next.dest = rt;
		use_rs = 1'b1;
		use_rt = 1'b0;
		o_jump = 1'b0;
		case (opcode)
			core_pkg::R_TYPE: begin
				use_rt = 1'b1;
				id_ex_next.dest = instr[15:11];
				id_ex_next.reg_write = 1'b1;
				id_ex_next.valid = 1'b1;
				case (funct)
					core_pkg::ADDU: id_ex_next.alu_op = core_pkg::ALU_ADD;
					core_pkg::SUBU: id_ex_next.alu_op = core_pkg::ALU_SUB;
					core_pkg::AND:  id_ex_next.alu_op = core_pkg::ALU_AND;
					core_pkg::OR:   id_ex_next.alu_op = core_pkg::ALU_OR;
					core_pkg::SLT:  id_ex_next.alu_op = core_pkg::ALU_SLT;
					default: begin
						// unknown funct including the all-zero nop
						id_ex_next.reg_write = 1'b0;
						id_ex_next.valid = 1'b0;
					end
				endcase
			end
			core_pkg::ADDIU, core_pkg::LW: begin
				id_ex_next.alu_src_imm = 1'b1;
				id_ex_next.reg_write = 1'b1;
				id_ex_next.mem_read = (opcode == core_pkg::LW);
				id_ex_next.mem_to_reg = (opcode == core_pkg::LW);
				id_ex_next.valid = 1'b1;
			end
			core_pkg::SW: begin
				use_rt = 1'b1;
				id_ex_next.alu_src_imm = 1'b1;
				id_ex_next.mem_write = 1'b1;
				id_ex_next.valid = 1'b1;
			end
			core_pkg::BEQ: begin
				use_rt = 1'b1;
				id_ex_next.alu_op = core_pkg::ALU_SUB;
				id_ex_next.branch = 1'b1;
				id_ex_next.valid = 1'b1;
			end
			core_pkg::J: begin
				use_rs = 1'b0;
				o_jump = 1'b1;
			end
			default: begin
				use_rs = 1'b0;
			end
		endcase
	end

	assign o_jump_target = {i_if_id.pc4[31:28], instr[25:0], 2'b00};

	// load in execute feeding this instruction
	assign o_stall = i_id_ex.valid && i_id_ex.mem_read && i_id_ex.dest != 5'd0 &&
		((use_rs && i_id_ex.dest == rs) || (use_rt && i_id_ex.dest == rt));

	always_ff @(posedge i_clk) begin
		if (i_reset || o_stall || i_branch_taken) begin
			o_id_ex.valid <= 1'b0;
			o_id_ex.reg_write <= 1'b0;
			o_id_ex.mem_read <= 1'b0;
			o_id_ex.mem_write <= 1'b0;
			o_id_ex.branch <= 1'b0;
		end else begin
			o_id_ex <= id_ex_next;
		end
	end

endmodule

//--- verilog/execute.sv
`timescale 1ns/1ps

module execute (
	input  logic              i_clk,
	input  logic              i_reset,
	input  core_pkg::id_ex_t  i_id_ex,
	input  core_pkg::wb_t     i_wb,
	output core_pkg::ex_mem_t o_ex_mem,
	output logic              o_branch_taken,
	output core_pkg::word_t   o_branch_target
);

	core_pkg::word_t rs_val;
	core_pkg::word_t rt_val;
	core_pkg::word_t op_b;
	core_pkg::word_t alu_res;

	// younger result in ex/mem wins over writeback
	function automatic core_pkg::word_t forward(
		input core_pkg::reg_addr_t r,
		input core_pkg::word_t     reg_data
	);
		if (r == 5'd0) begin
			return reg_data;
		end
		if (o_ex_mem.reg_write && o_ex_mem.dest == r) begin
			return o_ex_mem.alu_res;
		end
		if (i_wb.reg_write && i_wb.dest == r) begin
			return i_wb.data;
		end
		return reg_data;
	endfunction

	assign rs_val = forward(i_id_ex.rs, i_id_ex.rs_data);
	assign rt_val = forward(i_id_ex.rt, i_id_ex.rt_data);
	assign op_b = i_id_ex.alu_src_imm ? i_id_ex.imm : rt_val;

	always_comb begin
		case (i_id_ex.alu_op)
			core_pkg::ALU_ADD: alu_res = rs_val + op_b;
			core_pkg::ALU_SUB: alu_res = rs_val - op_b;
			core_pkg::ALU_AND: alu_res = rs_val & op_b;
			core_pkg::ALU_OR:  alu_res = rs_val | op_b;
			core_pkg::ALU_SLT: alu_res = {31'd0, $signed(rs_val) < $signed(op_b)};
			default:           alu_res = '0;
		endcase
	end

	// beq resolves here
	assign o_branch_taken = i_id_ex.valid && i_id_ex.branch && (rs_val == rt_val);
	assign o_branch_target = i_id_ex.pc4 + {i_id_ex.imm[29:0], 2'b00};

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_ex_mem.reg_write <= 1'b0;
			o_ex_mem.mem_read <= 1'b0;
			o_ex_mem.mem_write <= 1'b0;
			o_ex_mem.mem_to_reg <= 1'b0;
		end else begin
			o_ex_mem.alu_res <= alu_res;
			o_ex_mem.store_data <= rt_val;
			o_ex_mem.dest <= i_id_ex.dest;
			o_ex_mem.reg_write <= i_id_ex.reg_write;
			o_ex_mem.mem_read <= i_id_ex.mem_read;
			o_ex_mem.mem_write <= i_id_ex.mem_write;
			o_ex_mem.mem_to_reg <= i_id_ex.mem_to_reg;
		end
	end

endmodule

//--- verilog/fetch.sv
`timescale 1ns/1ps

module fetch (
	input  logic              i_clk,
	input  logic              i_reset,
	input  logic              i_stall,
	input  logic              i_jump,
	input  core_pkg::word_t   i_jump_target,
	input  logic              i_branch_taken,
	input  core_pkg::word_t   i_branch_target,
	input  core_pkg::word_t   i_instr,
	output core_pkg::word_t   o_pc,
	output core_pkg::if_id_t  o_if_id
);

	core_pkg::word_t pc4;
	core_pkg::word_t pc_next;

	assign pc4 = o_pc + 32'd4;

	// branch beats jump and jump beats stall
	always_comb begin
		if (i_branch_taken) begin
			pc_next = i_branch_target;
		end else if (i_jump) begin
			pc_next = i_jump_target;
		end else if (i_stall) begin
			pc_next = o_pc;
		end else begin
			pc_next = pc4;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_pc <= core_pkg::RESET_PC;
			o_if_id <= '0;
		end else begin
			o_pc <= pc_next;
			if (i_branch_taken || i_jump) begin
				// squash the wrong-path fetch
				o_if_id.instr <= '0;
			end else if (!i_stall) begin
				o_if_id.pc4 <= pc4;
				o_if_id.instr <= i_instr;
			end
		end
	end

endmodule

//--- verilog/mem.sv
`timescale 1ns/1ps

module mem (
	input  logic              i_clk,
	input  logic              i_reset,
	input  core_pkg::ex_mem_t i_ex_mem,
	input  core_pkg::word_t   i_read_data,
	output core_pkg::wb_t     o_wb
);

	core_pkg::word_t     alu_res_q;
	core_pkg::word_t     load_q;
	core_pkg::reg_addr_t dest_q;
	logic                reg_write_q;
	logic                mem_to_reg_q;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			reg_write_q <= 1'b0;
			mem_to_reg_q <= 1'b0;
		end else begin
			reg_write_q <= i_ex_mem.reg_write;
			mem_to_reg_q <= i_ex_mem.mem_to_reg;
		end
		alu_res_q <= i_ex_mem.alu_res;
		load_q <= i_read_data;
		dest_q <= i_ex_mem.dest;
	end

	// writeback select
	assign o_wb.reg_write = reg_write_q;
	assign o_wb.dest = dest_q;
	assign o_wb.data = mem_to_reg_q ? load_q : alu_res_q;

endmodule

//--- vlog.f
verilog/core_pkg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/mem.sv
verilog/core.sv
verification/tb_clock.sv
verification/tb_memory.sv
verification/core_tb.sv
